//--- include/exec_params.svh
`ifndef EXEC_PARAMS_SVH
`define EXEC_PARAMS_SVH

// integer register width
`define XLEN 64

// architectural register file
`define NUM_REGS 32
`define REG_IDX_W 5

// RV64 shift amount
`define SHAMT_W 6

`endif

//--- source/exu_info_pkg.sv
`default_nettype none

package exu_info_pkg;

  // class field, low 3 bits of the info word
  typedef enum logic [2:0] {
    EXU_NONE = 3'd0,
    EXU_ALU  = 3'd1,
    EXU_BJP  = 3'd2,
    EXU_LS   = 3'd3
  } exu_class_e;

  // op bits one-hot in [10:0]
  typedef struct packed {
    logic ebreak;
    logic wop;
    logic op_lui;
    logic op_and;
    logic op_or;
    logic op_xor;
    logic op_sltu;
    logic op_slt;
    logic op_sra;
    logic op_srl;
    logic op_sll;
    logic op_sub;
    logic op_add;
  } alu_flags_t;

  typedef struct packed {
    logic [4:0] rsvd;
    logic       bgeu;
    logic       bltu;
    logic       bge;
    logic       blt;
    logic       bne;
    logic       beq;
    logic       jalr;
    logic       jal;
  } bjp_flags_t;

  // load/store attribute word as it leaves the core
  typedef struct packed {
    logic size_dw;
    logic size_w;
    logic size_h;
    logic size_b;
    logic usign;
    logic store;
    logic load;
  } ls_info_t;

  typedef struct packed {
    logic [5:0] rsvd;
    ls_info_t   attr;
  } ls_flags_t;

  // payload meaning depends on the class field
  typedef union packed {
    alu_flags_t alu;
    bjp_flags_t bjp;
    ls_flags_t  ls;
  } exu_payload_u;

  typedef struct packed {
    exu_payload_u payload;
    exu_class_e   cls;
  } exu_info_t;

endpackage

`default_nettype wire

//--- source/pipe_pkg.sv
`default_nettype none
`include "exec_params.svh"

package pipe_pkg;

  // decode stage register contents
  typedef struct packed {
    logic                   valid;
    logic                   rd_wr_en;
    logic [`REG_IDX_W-1:0]  rd_idx;
    exu_info_pkg::exu_info_t info;
    logic [`XLEN-1:0]       op1;
    logic [`XLEN-1:0]       op2;
    logic [`XLEN-1:0]       jump_base;
    logic [`XLEN-1:0]       jump_off;
    logic [`XLEN-1:0]       store_data;
    logic [`XLEN-1:0]       pc;
  } dec_pkt_t;

  // execute stage register contents, feeds writeback and the core outputs
  typedef struct packed {
    logic                   valid;
    logic                   rd_wr_en;
    logic [`REG_IDX_W-1:0]  rd_idx;
    logic [`XLEN-1:0]       result;
    logic                   jump;
    logic [`XLEN-1:0]       jump_addr;
    exu_info_pkg::ls_info_t ls_info;
    logic [`XLEN-1:0]       ls_addr;
    logic [`XLEN-1:0]       store_data;
    logic                   ebreak;
    logic                   illegal;
  } exu_res_t;

endpackage

`default_nettype wire

//--- source/inst_decode.sv
`timescale 1ns/1ps
`default_nettype none
`include "exec_params.svh"

module inst_decode (
  input  logic                  clk,
  input  logic                  reset_i,
  input  logic                  inst_valid_i,
  input  logic [31:0]           inst_i,
  input  logic [`XLEN-1:0]      pc_i,
  output logic [`REG_IDX_W-1:0] rs1_idx_o,
  output logic [`REG_IDX_W-1:0] rs2_idx_o,
  input  logic [`XLEN-1:0]      rs1_data_i,
  input  logic [`XLEN-1:0]      rs2_data_i,
  output pipe_pkg::dec_pkt_t    dec_o
);
  import exu_info_pkg::*;
  import pipe_pkg::*;

  logic [6:0]       opcode;
  logic [2:0]       funct3;
  logic [6:0]       funct7;
  logic             is_imm;
  logic             is_w;
  logic             alt;
  logic             alu_legal;
  logic             legal;
  logic [`XLEN-1:0] imm_i;
  logic [`XLEN-1:0] imm_s;
  logic [`XLEN-1:0] imm_b;
  logic [`XLEN-1:0] imm_u;
  logic [`XLEN-1:0] imm_j;
  alu_flags_t       alu_f;
  bjp_flags_t       bjp_f;
  ls_flags_t        ls_f;
  dec_pkt_t         dec_d;
  dec_pkt_t         dec_q;

  assign opcode    = inst_i[6:0];
  assign funct3    = inst_i[14:12];
  assign funct7    = inst_i[31:25];
  assign is_imm    = ~opcode[5];
  assign is_w      = opcode[3];
  assign rs1_idx_o = inst_i[19:15];
  assign rs2_idx_o = inst_i[24:20];

  assign imm_i = {{(`XLEN-12){inst_i[31]}}, inst_i[31:20]};
  assign imm_s = {{(`XLEN-12){inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
  assign imm_b = {{(`XLEN-12){inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
  assign imm_u = {{(`XLEN-32){inst_i[31]}}, inst_i[31:12], 12'b0};
  assign imm_j = {{(`XLEN-20){inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

  // sub/sra select, only srai carries it among the immediate forms
  assign alt = inst_i[30] & (~is_imm | (funct3 == 3'd5));

  // funct7 and shamt checks for the four integer ALU opcodes
  always_comb begin
    if (!is_imm) begin
      alu_legal = (funct7 == {1'b0, inst_i[30], 5'b0}) &&
                  (!inst_i[30] || funct3 == 3'd0 || funct3 == 3'd5);
    end else if (funct3 == 3'd1 || funct3 == 3'd5) begin
      alu_legal = ({inst_i[31], inst_i[29:26]} == 5'b0) && !(is_w && inst_i[25]) &&
                  (funct3 == 3'd5 || !inst_i[30]);
    end else begin
      alu_legal = 1'b1;
    end
    // word forms exist for add/sub and shifts only
    if (is_w && funct3 != 3'd0 && funct3 != 3'd1 && funct3 != 3'd5) begin
      alu_legal = 1'b0;
    end
  end

  always_comb begin
    dec_d            = '0;
    dec_d.valid      = inst_valid_i;
    dec_d.rd_idx     = inst_i[11:7];
    dec_d.op1        = rs1_data_i;
    dec_d.op2        = rs2_data_i;
    dec_d.jump_base  = pc_i;
    dec_d.jump_off   = imm_b;
    dec_d.store_data = rs2_data_i;
    dec_d.pc         = pc_i;
    alu_f            = '0;
    bjp_f            = '0;
    ls_f             = '0;
    ls_f.attr.size_b  = funct3[1:0] == 2'd0;
    ls_f.attr.size_h  = funct3[1:0] == 2'd1;
    ls_f.attr.size_w  = funct3[1:0] == 2'd2;
    ls_f.attr.size_dw = funct3[1:0] == 2'd3;
    ls_f.attr.usign   = funct3[2];
    legal            = 1'b1;
    case (opcode)
      // OP, OP-32, OP-IMM, OP-IMM-32
      7'b0110011, 7'b0111011, 7'b0010011, 7'b0011011: begin
        dec_d.info.cls = EXU_ALU;
        dec_d.rd_wr_en = 1'b1;
        alu_f.wop      = is_w;
        legal          = alu_legal;
        if (is_imm) begin
          dec_d.op2 = imm_i;
        end
        case (funct3)
          3'd0: begin
            alu_f.op_sub = alt;
            alu_f.op_add = ~alt;
          end
          3'd1: alu_f.op_sll = 1'b1;
          3'd2: alu_f.op_slt = 1'b1;
          3'd3: alu_f.op_sltu = 1'b1;
          3'd4: alu_f.op_xor = 1'b1;
          3'd5: begin
            alu_f.op_sra = alt;
            alu_f.op_srl = ~alt;
          end
          3'd6: alu_f.op_or = 1'b1;
          default: alu_f.op_and = 1'b1;
        endcase
      end
      7'b0110111: begin
        dec_d.info.cls = EXU_ALU;
        dec_d.rd_wr_en = 1'b1;
        dec_d.op2      = imm_u;
        alu_f.op_lui   = 1'b1;
      end
      7'b0010111: begin
        dec_d.info.cls = EXU_ALU;
        dec_d.rd_wr_en = 1'b1;
        dec_d.op1      = pc_i;
        dec_d.op2      = imm_u;
        alu_f.op_add   = 1'b1;
      end
      // jal and jalr link through the adder as pc + 4
      7'b1101111, 7'b1100111: begin
        dec_d.info.cls = EXU_BJP;
        dec_d.rd_wr_en = 1'b1;
        dec_d.op1      = pc_i;
        dec_d.op2      = `XLEN'(4);
        bjp_f.jal      = opcode[3];
        bjp_f.jalr     = ~opcode[3];
        if (!opcode[3]) begin
          dec_d.jump_base = rs1_data_i;
          dec_d.jump_off  = imm_i;
          legal           = funct3 == 3'd0;
        end else begin
          dec_d.jump_off = imm_j;
        end
      end
      7'b1100011: begin
        dec_d.info.cls = EXU_BJP;
        legal          = funct3[2:1] != 2'b01;
        bjp_f.beq      = funct3 == 3'd0;
        bjp_f.bne      = funct3 == 3'd1;
        bjp_f.blt      = funct3 == 3'd4;
        bjp_f.bge      = funct3 == 3'd5;
        bjp_f.bltu     = funct3 == 3'd6;
        bjp_f.bgeu     = funct3 == 3'd7;
      end
      7'b0000011: begin
        dec_d.info.cls = EXU_LS;
        dec_d.rd_wr_en = 1'b1;
        dec_d.op2      = imm_i;
        ls_f.attr.load = 1'b1;
        legal          = funct3 != 3'd7;
      end
      7'b0100011: begin
        dec_d.info.cls  = EXU_LS;
        dec_d.op2       = imm_s;
        ls_f.attr.store = 1'b1;
        legal           = ~funct3[2];
      end
      // only ebreak of the system space, class stays NONE
      7'b1110011: begin
        alu_f.ebreak = 1'b1;
        legal        = inst_i == 32'h0010_0073;
      end
      default: legal = 1'b0;
    endcase

    case (dec_d.info.cls)
      EXU_BJP: dec_d.info.payload.bjp = bjp_f;
      EXU_LS:  dec_d.info.payload.ls  = ls_f;
      default: dec_d.info.payload.alu = alu_f;
    endcase
    // illegal is class NONE without the ebreak flag
    if (!legal) begin
      dec_d.info     = '0;
      dec_d.rd_wr_en = 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    dec_q <= dec_d;
    if (reset_i) begin
      dec_q.valid    <= 1'b0;
      dec_q.rd_wr_en <= 1'b0;
    end
  end

  assign dec_o = dec_q;

  assert property (@(posedge clk) disable iff (reset_i)
    dec_q.valid && dec_q.info.cls == EXU_ALU |-> $onehot(dec_q.info.payload.alu[10:0]));

endmodule

`default_nettype wire

//--- source/exu_alu_bjp.sv
`timescale 1ns/1ps
`default_nettype none
`include "exec_params.svh"

module exu_alu_bjp (
  input  logic               clk,
  input  logic               reset_i,
  input  pipe_pkg::dec_pkt_t dec_i,
  output pipe_pkg::exu_res_t res_o
);
  import exu_info_pkg::*;
  import pipe_pkg::*;

  alu_flags_t          alu;
  bjp_flags_t          bjp;
  ls_flags_t           ls;
  logic                ebreak;
  logic                sub_need;
  logic                add_need;
  logic                adder_cout;
  logic [`XLEN-1:0]    adder_in2;
  logic [`XLEN-1:0]    adder_res;
  logic                lt;
  logic                ltu;
  logic                eq;
  logic                taken;
  logic [`SHAMT_W-1:0] shamt;
  logic [`XLEN-1:0]    sll_res;
  logic [`XLEN-1:0]    srl_res;
  logic [`XLEN-1:0]    sra_res;
  logic [31:0]         srlw_res;
  logic [31:0]         sraw_res;
  logic [31:0]         word_res;
  logic [`XLEN-1:0]    full_res;
  logic [`XLEN-1:0]    alu_res;
  exu_res_t            res_d;
  exu_res_t            res_q;

  // each view of the payload is live only in its own class
  assign alu    = (dec_i.info.cls == EXU_ALU) ? dec_i.info.payload.alu : '0;
  assign bjp    = (dec_i.info.cls == EXU_BJP) ? dec_i.info.payload.bjp : '0;
  assign ls     = (dec_i.info.cls == EXU_LS) ? dec_i.info.payload.ls : '0;
  assign ebreak = (dec_i.info.cls == EXU_NONE) & dec_i.info.payload.alu.ebreak;

  // shared adder, subtract for compares and branches
  assign sub_need  = alu.op_sub | alu.op_slt | alu.op_sltu | bjp.beq | bjp.bne |
                     bjp.blt | bjp.bge | bjp.bltu | bjp.bgeu;
  assign add_need  = alu.op_add | alu.op_sub | bjp.jal | bjp.jalr;
  assign adder_in2 = sub_need ? ~dec_i.op2 : dec_i.op2;
  assign {adder_cout, adder_res} = {1'b0, dec_i.op1} + {1'b0, adder_in2} +
                                   {{`XLEN{1'b0}}, sub_need};

  // differing signs decide, else the sign of the difference
  assign lt  = (dec_i.op1[`XLEN-1] & ~dec_i.op2[`XLEN-1]) |
               (~(dec_i.op1[`XLEN-1] ^ dec_i.op2[`XLEN-1]) & adder_res[`XLEN-1]);
  assign ltu = ~adder_cout;
  assign eq  = ~|adder_res;

  assign taken = (bjp.beq & eq) | (bjp.bne & ~eq) | (bjp.blt & lt) | (bjp.bge & ~lt) |
                 (bjp.bltu & ltu) | (bjp.bgeu & ~ltu);

  // word shifts use five bits of the amount
  assign shamt    = alu.wop ? {1'b0, dec_i.op2[4:0]} : dec_i.op2[`SHAMT_W-1:0];
  assign sll_res  = dec_i.op1 << shamt;
  assign srl_res  = dec_i.op1 >> shamt;
  assign sra_res  = $signed(dec_i.op1) >>> shamt;
  assign srlw_res = dec_i.op1[31:0] >> shamt;
  assign sraw_res = $signed(dec_i.op1[31:0]) >>> shamt;

  assign full_res = ({`XLEN{add_need}} & adder_res) |
                    ({`XLEN{alu.op_sll}} & sll_res) |
                    ({`XLEN{alu.op_srl}} & srl_res) |
                    ({`XLEN{alu.op_sra}} & sra_res) |
                    ({`XLEN{alu.op_slt}} & {{(`XLEN-1){1'b0}}, lt}) |
                    ({`XLEN{alu.op_sltu}} & {{(`XLEN-1){1'b0}}, ltu}) |
                    ({`XLEN{alu.op_xor}} & (dec_i.op1 ^ dec_i.op2)) |
                    ({`XLEN{alu.op_or}} & (dec_i.op1 | dec_i.op2)) |
                    ({`XLEN{alu.op_and}} & (dec_i.op1 & dec_i.op2)) |
                    ({`XLEN{alu.op_lui}} & dec_i.op2);

  // right shifts of a word need the low half shifted on its own
  assign word_res = ({32{alu.op_srl}} & srlw_res) |
                    ({32{alu.op_sra}} & sraw_res) |
                    ({32{~(alu.op_srl | alu.op_sra)}} & full_res[31:0]);
  assign alu_res  = alu.wop ? {{(`XLEN-32){word_res[31]}}, word_res} : full_res;

  always_comb begin
    res_d.valid      = dec_i.valid;
    res_d.rd_wr_en   = dec_i.valid & dec_i.rd_wr_en & ~ls.attr.load;
    res_d.rd_idx     = dec_i.rd_idx;
    res_d.result     = alu_res;
    res_d.jump       = dec_i.valid & (bjp.jal | bjp.jalr | taken);
    res_d.jump_addr  = dec_i.jump_base + dec_i.jump_off;
    res_d.ls_info    = dec_i.valid ? ls.attr : '0;
    res_d.ls_addr    = adder_res;
    res_d.store_data = ls.attr.store ? dec_i.store_data : '0;
    res_d.ebreak     = dec_i.valid & ebreak;
    res_d.illegal    = dec_i.valid & (dec_i.info.cls == EXU_NONE) & ~ebreak;
  end

  always_ff @(posedge clk) begin
    res_q <= res_d;
    if (reset_i) begin
      res_q.valid    <= 1'b0;
      res_q.rd_wr_en <= 1'b0;
      res_q.jump     <= 1'b0;
      res_q.ebreak   <= 1'b0;
      res_q.illegal  <= 1'b0;
    end
  end

  assign res_o = res_q;

  // only a branch or jump redirects
  assert property (@(posedge clk) disable iff (reset_i)
    dec_i.valid && dec_i.info.cls != EXU_BJP |=> !res_q.jump);

  // link value comes back as the return address of the issuing pc
  assert property (@(posedge clk) disable iff (reset_i)
    dec_i.valid && (bjp.jal || bjp.jalr) |=> res_q.result == $past(dec_i.pc) + `XLEN'(4));

endmodule

`default_nettype wire

//--- source/wb_regfile.sv
`timescale 1ns/1ps
`default_nettype none
`include "exec_params.svh"

module wb_regfile (
  input  logic                  clk,
  input  logic                  reset_i,
  input  logic [`REG_IDX_W-1:0] rs1_idx_i,
  input  logic [`REG_IDX_W-1:0] rs2_idx_i,
  output logic [`XLEN-1:0]      rs1_data_o,
  output logic [`XLEN-1:0]      rs2_data_o,
  input  pipe_pkg::exu_res_t    res_i
);
  logic [`XLEN-1:0] regs [`NUM_REGS];
  logic             wr_en;

  // x0 is never written and keeps its reset zero
  assign wr_en = res_i.valid & res_i.rd_wr_en & (res_i.rd_idx != '0);

  always_ff @(posedge clk) begin
    if (reset_i) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[res_i.rd_idx] <= res_i.result;
    end
  end

  // combinational reads in the same cycle as the decode request
  assign rs1_data_o = regs[rs1_idx_i];
  assign rs2_data_o = regs[rs2_idx_i];

  // x0 reads zero on both ports
  assert property (@(posedge clk) disable iff (reset_i)
    (rs1_idx_i != '0 || rs1_data_o == '0) && (rs2_idx_i != '0 || rs2_data_o == '0));

endmodule

`default_nettype wire

//--- source/exec_core.sv
`timescale 1ns/1ps
`default_nettype none
`include "exec_params.svh"

module exec_core (
  input  logic                   clk,
  input  logic                   reset_i,
  input  logic                   inst_valid_i,
  input  logic [31:0]            inst_i,
  input  logic [`XLEN-1:0]       pc_i,
  output logic                   res_valid_o,
  output logic                   rd_wr_en_o,
  output logic [`REG_IDX_W-1:0]  rd_idx_o,
  output logic [`XLEN-1:0]       alu_res_o,
  output logic                   jump_o,
  output logic [`XLEN-1:0]       jump_addr_o,
  output exu_info_pkg::ls_info_t ls_info_o,
  output logic [`XLEN-1:0]       ls_addr_o,
  output logic [`XLEN-1:0]       store_data_o,
  output logic                   ebreak_o,
  output logic                   illegal_o
);
  import pipe_pkg::*;

  logic [`REG_IDX_W-1:0] rs1_idx;
  logic [`REG_IDX_W-1:0] rs2_idx;
  logic [`XLEN-1:0]      rs1_data;
  logic [`XLEN-1:0]      rs2_data;
  dec_pkt_t              dec;
  exu_res_t              res;

  inst_decode u_decode (
    .clk          (clk),
    .reset_i      (reset_i),
    .inst_valid_i (inst_valid_i),
    .inst_i       (inst_i),
    .pc_i         (pc_i),
    .rs1_idx_o    (rs1_idx),
    .rs2_idx_o    (rs2_idx),
    .rs1_data_i   (rs1_data),
    .rs2_data_i   (rs2_data),
    .dec_o        (dec)
  );

  exu_alu_bjp u_exu (
    .clk     (clk),
    .reset_i (reset_i),
    .dec_i   (dec),
    .res_o   (res)
  );

  wb_regfile u_regfile (
    .clk        (clk),
    .reset_i    (reset_i),
    .rs1_idx_i  (rs1_idx),
    .rs2_idx_i  (rs2_idx),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .res_i      (res)
  );

  assign res_valid_o  = res.valid;
  assign rd_wr_en_o   = res.rd_wr_en;
  assign rd_idx_o     = res.rd_idx;
  assign alu_res_o    = res.result;
  assign jump_o       = res.jump;
  assign jump_addr_o  = res.jump_addr;
  assign ls_info_o    = res.ls_info;
  assign ls_addr_o    = res.ls_addr;
  assign store_data_o = res.store_data;
  assign ebreak_o     = res.ebreak;
  assign illegal_o    = res.illegal;

endmodule

`default_nettype wire

//--- dv/exec_core_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "exec_params.svh"

module exec_core_tb;
  import exu_info_pkg::*;

  localparam int OPC_OP    = 'h33;
  localparam int OPC_OP32  = 'h3B;
  localparam int OPC_IMM   = 'h13;
  localparam int OPC_LUI   = 'h37;
  localparam int OPC_AUIPC = 'h17;
  localparam int OPC_JALR  = 'h67;
  localparam int OPC_LOAD  = 'h03;

  // one issued instruction and what the core must report for it
  typedef struct packed {
    logic [31:0]      inst;
    logic [`XLEN-1:0] pc;
    logic             wr_en;
    logic [`XLEN-1:0] res;
    logic             jump;
    logic [`XLEN-1:0] addr;
    ls_info_t         ls_info;
    logic [`XLEN-1:0] store_data;
    logic             ebreak;
    logic             illegal;
  } entry_t;

  logic                  clk;
  logic                  reset_i;
  logic                  inst_valid_i;
  logic [31:0]           inst_i;
  logic [`XLEN-1:0]      pc_i;
  logic                  res_valid_o;
  logic                  rd_wr_en_o;
  logic [`REG_IDX_W-1:0] rd_idx_o;
  logic [`XLEN-1:0]      alu_res_o;
  logic                  jump_o;
  logic [`XLEN-1:0]      jump_addr_o;
  ls_info_t              ls_info_o;
  logic [`XLEN-1:0]      ls_addr_o;
  logic [`XLEN-1:0]      store_data_o;
  logic                  ebreak_o;
  logic                  illegal_o;
  entry_t                tbl[$];
  bit                    table_built;

  exec_core dut_i (
    .clk          (clk),
    .reset_i      (reset_i),
    .inst_valid_i (inst_valid_i),
    .inst_i       (inst_i),
    .pc_i         (pc_i),
    .res_valid_o  (res_valid_o),
    .rd_wr_en_o   (rd_wr_en_o),
    .rd_idx_o     (rd_idx_o),
    .alu_res_o    (alu_res_o),
    .jump_o       (jump_o),
    .jump_addr_o  (jump_addr_o),
    .ls_info_o    (ls_info_o),
    .ls_addr_o    (ls_addr_o),
    .store_data_o (store_data_o),
    .ebreak_o     (ebreak_o),
    .illegal_o    (illegal_o)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // RV64I encoders
  function automatic logic [31:0] r_type(int f7, int f3, int rd, int rs1, int rs2, int op);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
  endfunction

  function automatic logic [31:0] i_type(int imm, int f3, int rd, int rs1, int op);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
  endfunction

  function automatic logic [31:0] s_type(int off, int f3, int rs1, int rs2);
    return {off[11:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] b_type(int off, int f3, int rs1, int rs2);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'h63};
  endfunction

  function automatic logic [31:0] u_type(int imm, int rd, int op);
    return {imm[19:0], rd[4:0], op[6:0]};
  endfunction

  function automatic logic [31:0] j_type(int off, int rd);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'h6F};
  endfunction

  task automatic add_alu(input logic [31:0] inst, input logic [63:0] pc, input logic [63:0] res);
    entry_t e;
    e = '0;
    e.inst  = inst;
    e.pc    = pc;
    e.wr_en = 1'b1;
    e.res   = res;
    tbl.push_back(e);
  endtask

  task automatic add_branch(input logic [31:0] inst, input logic [63:0] pc, input logic taken,
                            input logic [63:0] target);
    entry_t e;
    e = '0;
    e.inst = inst;
    e.pc   = pc;
    e.jump = taken;
    e.addr = target;
    tbl.push_back(e);
  endtask

  task automatic add_jump(input logic [31:0] inst, input logic [63:0] pc,
                          input logic [63:0] link, input logic [63:0] target);
    entry_t e;
    e = '0;
    e.inst  = inst;
    e.pc    = pc;
    e.wr_en = 1'b1;
    e.res   = link;
    e.jump  = 1'b1;
    e.addr  = target;
    tbl.push_back(e);
  endtask

  task automatic add_ls(input logic [31:0] inst, input ls_info_t info, input logic [63:0] addr,
                        input logic [63:0] data);
    entry_t e;
    e = '0;
    e.inst       = inst;
    e.ls_info    = info;
    e.addr       = addr;
    e.store_data = data;
    tbl.push_back(e);
  endtask

  task automatic add_trap(input logic [31:0] inst, input logic eb, input logic il);
    entry_t e;
    e = '0;
    e.inst    = inst;
    e.ebreak  = eb;
    e.illegal = il;
    tbl.push_back(e);
  endtask

  task automatic build_table();
    // constants x1 = -5, x2 = 7, x3 = lui 0x80000 and x4 = 40
    add_alu(i_type(-5, 0, 1, 0, OPC_IMM), 64'h0, 64'hFFFF_FFFF_FFFF_FFFB);
    add_alu(i_type(7, 0, 2, 0, OPC_IMM), 64'h0, 64'h7);
    add_alu(u_type('h80000, 3, OPC_LUI), 64'h0, 64'hFFFF_FFFF_8000_0000);
    add_alu(i_type(40, 0, 4, 0, OPC_IMM), 64'h0, 64'h28);
    add_alu(r_type(0, 0, 5, 1, 2, OPC_OP), 64'h0, 64'h2);
    add_alu(r_type('h20, 0, 6, 1, 2, OPC_OP), 64'h0, 64'hFFFF_FFFF_FFFF_FFF4);
    add_alu(r_type(0, 7, 7, 1, 2, OPC_OP), 64'h0, 64'h3);
    add_alu(r_type(0, 6, 8, 1, 2, OPC_OP), 64'h0, 64'hFFFF_FFFF_FFFF_FFFF);
    add_alu(r_type(0, 4, 9, 1, 2, OPC_OP), 64'h0, 64'hFFFF_FFFF_FFFF_FFFC);
    add_alu(r_type(0, 1, 10, 2, 4, OPC_OP), 64'h0, 64'h0000_0700_0000_0000);
    add_alu(r_type(0, 5, 11, 3, 4, OPC_OP), 64'h0, 64'h0000_0000_00FF_FFFF);
    add_alu(r_type('h20, 5, 12, 3, 4, OPC_OP), 64'h0, 64'hFFFF_FFFF_FFFF_FFFF);
    add_alu(r_type(0, 2, 13, 1, 2, OPC_OP), 64'h0, 64'h1);
    add_alu(r_type(0, 3, 14, 1, 2, OPC_OP), 64'h0, 64'h0);
    add_alu(r_type(0, 2, 15, 2, 3, OPC_OP), 64'h0, 64'h0);
    add_alu(r_type(0, 3, 16, 2, 3, OPC_OP), 64'h0, 64'h1);
    // word ops on x17 = 0x7ffff000
    add_alu(u_type('h7FFFF, 17, OPC_LUI), 64'h0, 64'h0000_0000_7FFF_F000);
    add_alu(r_type(0, 0, 18, 17, 17, OPC_OP32), 64'h0, 64'hFFFF_FFFF_FFFF_E000);
    add_alu(r_type(0, 1, 19, 1, 4, OPC_OP32), 64'h0, 64'hFFFF_FFFF_FFFF_FB00);
    add_alu(r_type(0, 5, 20, 3, 4, OPC_OP32), 64'h0, 64'h0000_0000_0080_0000);
    add_alu(r_type('h20, 5, 21, 3, 4, OPC_OP32), 64'h0, 64'hFFFF_FFFF_FF80_0000);
    // each branch taken and then not taken
    add_branch(b_type(32, 0, 1, 1), 64'h1000, 1'b1, 64'h1020);
    add_branch(b_type(-16, 0, 1, 2), 64'h1000, 1'b0, 64'h0FF0);
    add_branch(b_type(32, 1, 1, 2), 64'h1000, 1'b1, 64'h1020);
    add_branch(b_type(-16, 1, 2, 2), 64'h1000, 1'b0, 64'h0FF0);
    add_branch(b_type(32, 4, 1, 2), 64'h1000, 1'b1, 64'h1020);
    add_branch(b_type(-16, 4, 2, 1), 64'h1000, 1'b0, 64'h0FF0);
    add_branch(b_type(32, 5, 2, 1), 64'h1000, 1'b1, 64'h1020);
    add_branch(b_type(-16, 5, 1, 2), 64'h1000, 1'b0, 64'h0FF0);
    add_branch(b_type(32, 6, 2, 1), 64'h1000, 1'b1, 64'h1020);
    add_branch(b_type(-16, 6, 1, 2), 64'h1000, 1'b0, 64'h0FF0);
    add_branch(b_type(32, 7, 1, 2), 64'h1000, 1'b1, 64'h1020);
    add_branch(b_type(-16, 7, 2, 1), 64'h1000, 1'b0, 64'h0FF0);
    // jalr goes back through the link of the jal
    add_jump(j_type(256, 22), 64'h2000, 64'h2004, 64'h2100);
    add_jump(i_type(-4, 0, 23, 22, OPC_JALR), 64'h3000, 64'h3004, 64'h2000);
    add_ls(i_type(16, 0, 24, 17, OPC_LOAD), 7'b0001001, 64'h7FFF_F010, 64'h0);
    add_ls(i_type(2, 5, 24, 2, OPC_LOAD), 7'b0010101, 64'h9, 64'h0);
    add_ls(i_type(-4, 2, 24, 17, OPC_LOAD), 7'b0100001, 64'h7FFF_EFFC, 64'h0);
    add_ls(i_type(0, 6, 24, 4, OPC_LOAD), 7'b0100101, 64'h28, 64'h0);
    add_ls(i_type(8, 3, 24, 17, OPC_LOAD), 7'b1000001, 64'h7FFF_F008, 64'h0);
    add_ls(i_type(1, 4, 24, 0, OPC_LOAD), 7'b0001101, 64'h1, 64'h0);
    add_ls(i_type(6, 1, 24, 2, OPC_LOAD), 7'b0010001, 64'hD, 64'h0);
    add_ls(s_type(1, 0, 17, 2), 7'b0001010, 64'h7FFF_F001, 64'h7);
    add_ls(s_type(2, 1, 17, 3), 7'b0010010, 64'h7FFF_F002, 64'hFFFF_FFFF_8000_0000);
    add_ls(s_type(-4, 2, 17, 1), 7'b0100010, 64'h7FFF_EFFC, 64'hFFFF_FFFF_FFFF_FFFB);
    add_ls(s_type(-8, 3, 17, 18), 7'b1000010, 64'h7FFF_EFF8, 64'hFFFF_FFFF_FFFF_E000);
    // x24 was only ever a load target
    add_alu(r_type(0, 0, 25, 24, 0, OPC_OP), 64'h0, 64'h0);
    add_alu(i_type(99, 0, 0, 0, OPC_IMM), 64'h0, 64'h63);
    add_alu(r_type(0, 0, 26, 0, 2, OPC_OP), 64'h0, 64'h7);
    add_trap(32'h0010_0073, 1'b1, 1'b0);
    // undefined opcode with rd = x5
    add_trap(32'h0000_02FF, 1'b0, 1'b1);
    add_alu(r_type(0, 0, 27, 5, 0, OPC_OP), 64'h0, 64'h2);
    add_alu(u_type(1, 28, OPC_AUIPC), 64'h4000, 64'h5000);
  endtask

  task automatic check_word(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else begin
      $display("ERROR at %0t ns: %s expected %h actual %h", $time, name, exp, got);
      $display("Something failed");
      $fatal(1, "output mismatch");
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    assert (got === exp) else begin
      $display("ERROR at %0t ns: %s expected %b actual %b", $time, name, exp, got);
      $display("Something failed");
      $fatal(1, "output mismatch");
    end
  endtask

  task automatic check_outputs(input entry_t e);
    check_bit("res_valid_o", res_valid_o, 1'b1);
    check_bit("rd_wr_en_o", rd_wr_en_o, e.wr_en);
    if (e.wr_en) begin
      check_word("rd_idx_o", 64'(rd_idx_o), 64'(e.inst[11:7]));
      check_word("alu_res_o", alu_res_o, e.res);
    end
    check_bit("jump_o", jump_o, e.jump);
    // branch, jal and jalr opcodes share bits 6:4
    if (e.inst[6:4] == 3'b110) begin
      check_word("jump_addr_o", jump_addr_o, e.addr);
    end
    check_word("ls_info_o", 64'(ls_info_o), 64'(e.ls_info));
    if (e.ls_info != '0) begin
      check_word("ls_addr_o", ls_addr_o, e.addr);
    end
    check_word("store_data_o", store_data_o, e.store_data);
    check_bit("ebreak_o", ebreak_o, e.ebreak);
    check_bit("illegal_o", illegal_o, e.illegal);
  endtask

  initial begin
    wait (table_built);
    repeat (tbl.size() * 4 + 100) @(posedge clk);
    $display("timeout: the table did not finish within the cycle limit");
    $display("Something failed");
    $fatal(1, "watchdog expired");
  end

  initial begin
    reset_i      = 1'b1;
    inst_valid_i = 1'b0;
    inst_i       = '0;
    pc_i         = '0;
    build_table();
    table_built = 1'b1;
    repeat (8) @(posedge clk);
    reset_i <= 1'b0;
    @(negedge clk);
    check_bit("res_valid_o", res_valid_o, 1'b0);
    check_bit("rd_wr_en_o", rd_wr_en_o, 1'b0);
    check_bit("jump_o", jump_o, 1'b0);
    check_bit("ebreak_o", ebreak_o, 1'b0);
    check_bit("illegal_o", illegal_o, 1'b0);
    foreach (tbl[k]) begin
      @(posedge clk);
      inst_valid_i <= 1'b1;
      inst_i       <= tbl[k].inst;
      pc_i         <= tbl[k].pc;
      @(posedge clk);
      inst_valid_i <= 1'b0;
      // result register loads on the next edge
      @(posedge clk);
      @(negedge clk);
      check_outputs(tbl[k]);
      @(posedge clk);
    end
    $display("Everything OK");
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+include
source/exu_info_pkg.sv
source/pipe_pkg.sv
source/inst_decode.sv
source/exu_alu_bjp.sv
source/wb_regfile.sv
source/exec_core.sv
dv/exec_core_tb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f filelist.f --top-module exec_core_tb -Mdir obj_dir
	out=$$(./obj_dir/Vexec_core_tb); echo "$$out"; \
	echo "$$out" | grep -q "^Everything OK$$"

clean:
	rm -rf obj_dir
